// File: source/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// address split, tag | index | offset
`define DC_TAG_W      24
`define DC_INDEX_W    4
`define DC_OFFSET_W   4
`define DC_ADDR_W     32

// line geometry
`define DC_WORDS      4
`define DC_LINE_W     128
`define DC_LINE_BYTES 16
`define DC_SETS       16
`define DC_WAYS       2

// pipe op encodings
`define DC_OP_READ    1'b0
`define DC_OP_WRITE   1'b1

`endif

// File: source/dcache_pkg.sv
`include "dcache_macros.svh"

package dcache_pkg;

    // address fields
    typedef logic [`DC_TAG_W-1:0]    tag_t;
    typedef logic [`DC_INDEX_W-1:0]  index_t;
    typedef logic [`DC_OFFSET_W-1:0] offset_t;

    // word inside a line
    typedef logic [$clog2(`DC_WORDS)-1:0] word_sel_t;

    // whole line and its byte mask
    typedef logic [`DC_LINE_W-1:0]     line_t;
    typedef logic [`DC_LINE_BYTES-1:0] line_strb_t;

    typedef logic [$clog2(`DC_WAYS)-1:0] way_t;

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        LOOKUP  = 3'd1,
        MISS    = 3'd2,
        REPLACE = 3'd3,
        REFILL  = 3'd4
    } main_state_t;

endpackage

// File: source/way_ram.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module way_ram #(
    parameter type T     = logic,
    parameter int  DEPTH = `DC_SETS
) (
    input  logic               clk,
    input  dcache_pkg::index_t addr,
    input  logic               we,
    input  T                   wdata,
    output T                   rdata
);

    T mem [DEPTH];

    // write-first, new data shows on the read port right away
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
            rdata <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

// File: source/way_meta.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module way_meta (
    input  logic               clk,
    input  logic               resetn,
    input  dcache_pkg::index_t index,
    input  dcache_pkg::tag_t   tag,
    input  dcache_pkg::tag_t   tag_way0,
    input  dcache_pkg::tag_t   tag_way1,
    input  dcache_pkg::way_t   set_way,
    input  logic               set_valid,
    input  logic               set_dirty,
    input  logic               advance_victim,
    output logic               hit,
    output dcache_pkg::way_t   hit_way,
    output dcache_pkg::way_t   victim_way,
    output logic               victim_dirty
);

    import dcache_pkg::*;

    logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid_bits;
    logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty_bits;
    logic [`DC_WAYS-1:0]               hit_w;
    way_t                              victim_q;

    // a refill writes valid and the new dirty state, a store hit only marks dirty
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (set_valid) begin
            valid_bits[set_way][index] <= 1'b1;
            dirty_bits[set_way][index] <= set_dirty;
        end else if (set_dirty) begin
            dirty_bits[set_way][index] <= 1'b1;
        end
    end

    // round robin, steps once per completed refill
    always_ff @(posedge clk) begin
        if (!resetn) begin
            victim_q <= '0;
        end else if (advance_victim) begin
            victim_q <= victim_q + 1'b1;
        end
    end

    assign hit_w[0] = valid_bits[0][index] && (tag_way0 == tag);
    assign hit_w[1] = valid_bits[1][index] && (tag_way1 == tag);

    assign hit          = |hit_w;
    assign hit_way      = hit_w[1];
    assign victim_way   = victim_q;
    assign victim_dirty = valid_bits[victim_q][index] && dirty_bits[victim_q][index];

    a_one_way_hit: assert property (@(posedge clk) disable iff (!resetn)
        !(hit_w[0] && hit_w[1]));

endmodule

// File: source/refill_buffer.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module refill_buffer (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   start,
    input  logic                   ret_valid,
    input  logic                   ret_last,
    input  logic [31:0]            ret_data,
    input  dcache_pkg::line_t      store_line,
    input  dcache_pkg::line_strb_t store_strb,
    output dcache_pkg::line_t      line,
    output logic                   line_done
);

    import dcache_pkg::*;

    line_t     buf_q;
    word_sel_t cnt;
    logic      filling;

    // words come back in order from word 0
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt       <= '0;
            filling   <= 1'b0;
            line_done <= 1'b0;
        end else begin
            line_done <= ret_valid && ret_last && filling;
            if (start) begin
                cnt     <= '0;
                filling <= 1'b1;
            end else if (ret_valid && filling) begin
                cnt <= cnt + 1'b1;
                if (ret_last) begin
                    filling <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            buf_q <= '0;
        end else if (ret_valid && filling) begin
            buf_q[cnt*32 +: 32] <= ret_data;
        end
    end

    // pending store bytes win over memory data
    always_comb begin
        for (int i = 0; i < `DC_LINE_BYTES; i++) begin
            line[8*i +: 8] = store_strb[i] ? store_line[8*i +: 8] : buf_q[8*i +: 8];
        end
    end

    a_no_stray_return: assert property (@(posedge clk) disable iff (!resetn)
        ret_valid |-> filling);

endmodule

// File: source/dcache_ctrl.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    valid,
    input  logic                    op,
    input  dcache_pkg::tag_t        tag,
    input  dcache_pkg::index_t      index,
    input  dcache_pkg::offset_t     offset,
    input  logic [3:0]              wstrb,
    input  logic [31:0]             wdata,
    output logic                    addr_ok,
    output logic                    data_ok,
    output logic [31:0]             rdata,
    output logic                    rd_req,
    output logic [`DC_ADDR_W-1:0]   rd_addr,
    input  logic                    rd_rdy,
    output logic                    wr_req,
    output logic [`DC_ADDR_W-1:0]   wr_addr,
    output dcache_pkg::line_t       wr_data,
    input  logic                    wr_rdy,
    input  logic                    hit,
    input  dcache_pkg::way_t        hit_way,
    input  dcache_pkg::way_t        victim_way,
    input  logic                    victim_dirty,
    input  dcache_pkg::tag_t        tag_q0,
    input  dcache_pkg::tag_t        tag_q1,
    input  dcache_pkg::line_t       line_q0,
    input  dcache_pkg::line_t       line_q1,
    input  dcache_pkg::line_t       refill_line,
    input  logic                    refill_done,
    output dcache_pkg::index_t      ram_index,
    output logic                    tag_we0,
    output logic                    tag_we1,
    output logic                    data_we0,
    output logic                    data_we1,
    output dcache_pkg::tag_t        ram_wtag,
    output dcache_pkg::line_t       ram_wline,
    output dcache_pkg::way_t        set_way,
    output logic                    set_valid,
    output logic                    set_dirty,
    output logic                    advance_victim,
    output logic                    refill_start,
    output dcache_pkg::line_t       store_line,
    output dcache_pkg::line_strb_t  store_strb
);

    import dcache_pkg::*;

    main_state_t state;
    logic        op_reg;
    tag_t        tag_reg;
    index_t      index_reg;
    word_sel_t   word_reg;
    logic [3:0]  wstrb_reg;
    logic [31:0] wdata_reg;
    logic        accept;
    logic        hit_write;
    logic        refill_write;
    line_t       hit_line;
    line_t       merged_line;
    line_t       rd_line;

    // a read hit frees the pipe in its lookup cycle
    assign addr_ok = (state == IDLE) || (state == LOOKUP && hit && op_reg == `DC_OP_READ);
    assign accept  = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (accept) begin
            op_reg    <= op;
            tag_reg   <= tag;
            index_reg <= index;
            word_reg  <= offset[`DC_OFFSET_W-1:2];
            wstrb_reg <= wstrb;
            wdata_reg <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (accept) state <= LOOKUP;
                LOOKUP: begin
                    if (!hit) begin
                        state <= MISS;
                    end else if (!accept) begin
                        state <= IDLE;
                    end
                end
                // clean victims skip the write-back
                MISS:    if (!victim_dirty || wr_rdy) state <= REPLACE;
                REPLACE: if (rd_rdy) state <= REFILL;
                REFILL:  if (refill_done) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // pending store spread over the line, strobe picks the word
    assign store_line = {`DC_WORDS{wdata_reg}};
    assign store_strb = (op_reg == `DC_OP_WRITE) ?
                        (line_strb_t'(wstrb_reg) << {word_reg, 2'b00}) : '0;

    always_comb begin
        hit_line = hit_way ? line_q1 : line_q0;
        for (int i = 0; i < `DC_LINE_BYTES; i++) begin
            merged_line[8*i +: 8] = store_strb[i] ? store_line[8*i +: 8] : hit_line[8*i +: 8];
        end
    end

    assign hit_write    = (state == LOOKUP) && hit && (op_reg == `DC_OP_WRITE);
    assign refill_write = (state == REFILL) && refill_done;

    assign ram_index = accept ? index : index_reg;
    assign ram_wtag  = tag_reg;
    assign ram_wline = refill_write ? refill_line : merged_line;
    assign tag_we0   = refill_write && (victim_way == 1'b0);
    assign tag_we1   = refill_write && (victim_way == 1'b1);
    assign data_we0  = (hit_write && hit_way == 1'b0) || tag_we0;
    assign data_we1  = (hit_write && hit_way == 1'b1) || tag_we1;

    assign set_way        = refill_write ? victim_way : hit_way;
    assign set_valid      = refill_write;
    assign set_dirty      = refill_write ? (op_reg == `DC_OP_WRITE) : hit_write;
    assign advance_victim = refill_write;
    assign refill_start   = (state == REPLACE) && rd_rdy;

    // stores answer in lookup even on a miss
    assign data_ok = ((state == LOOKUP) && (op_reg == `DC_OP_WRITE || hit))
                  || (refill_write && op_reg == `DC_OP_READ);
    assign rd_line = (state == REFILL) ? refill_line : hit_line;
    assign rdata   = rd_line[word_reg*32 +: 32];

    assign rd_req  = (state == REPLACE);
    assign rd_addr = {tag_reg, index_reg, {`DC_OFFSET_W{1'b0}}};
    assign wr_req  = (state == MISS) && victim_dirty;
    assign wr_addr = {(victim_way ? tag_q1 : tag_q0), index_reg, {`DC_OFFSET_W{1'b0}}};
    assign wr_data = victim_way ? line_q1 : line_q0;

    // a finished line only comes back while the FSM waits for it
    a_refill_in_refill: assert property (@(posedge clk) disable iff (!resetn)
        refill_done |-> (state == REFILL));

endmodule

// File: source/dcache.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  valid,
    input  logic                  op,
    input  dcache_pkg::tag_t      tag,
    input  dcache_pkg::index_t    index,
    input  dcache_pkg::offset_t   offset,
    input  logic [3:0]            wstrb,
    input  logic [31:0]           wdata,
    output logic                  addr_ok,
    output logic                  data_ok,
    output logic [31:0]           rdata,
    output logic                  rd_req,
    output logic [`DC_ADDR_W-1:0] rd_addr,
    input  logic                  rd_rdy,
    input  logic                  ret_valid,
    input  logic                  ret_last,
    input  logic [31:0]           ret_data,
    output logic                  wr_req,
    output logic [`DC_ADDR_W-1:0] wr_addr,
    output dcache_pkg::line_t     wr_data,
    input  logic                  wr_rdy
);

    import dcache_pkg::*;

    logic       hit;
    way_t       hit_way;
    way_t       victim_way;
    logic       victim_dirty;
    tag_t       tag_q0;
    tag_t       tag_q1;
    line_t      line_q0;
    line_t      line_q1;
    line_t      refill_line;
    logic       refill_done;
    index_t     ram_index;
    logic       tag_we0;
    logic       tag_we1;
    logic       data_we0;
    logic       data_we1;
    tag_t       ram_wtag;
    line_t      ram_wline;
    way_t       set_way;
    logic       set_valid;
    logic       set_dirty;
    logic       advance_victim;
    logic       refill_start;
    line_t      store_line;
    line_strb_t store_strb;

    dcache_ctrl u_ctrl (.*);

    // hit check uses the request held by the controller
    way_meta u_meta (
        .clk            (clk),
        .resetn         (resetn),
        .index          (u_ctrl.index_reg),
        .tag            (u_ctrl.tag_reg),
        .tag_way0       (tag_q0),
        .tag_way1       (tag_q1),
        .set_way        (set_way),
        .set_valid      (set_valid),
        .set_dirty      (set_dirty),
        .advance_victim (advance_victim),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .victim_dirty   (victim_dirty)
    );

    refill_buffer u_refill (
        .clk        (clk),
        .resetn     (resetn),
        .start      (refill_start),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .ret_data   (ret_data),
        .store_line (store_line),
        .store_strb (store_strb),
        .line       (refill_line),
        .line_done  (refill_done)
    );

    way_ram #(.T(tag_t)) u_tag0 (
        .clk(clk), .addr(ram_index), .we(tag_we0), .wdata(ram_wtag), .rdata(tag_q0)
    );
    way_ram #(.T(tag_t)) u_tag1 (
        .clk(clk), .addr(ram_index), .we(tag_we1), .wdata(ram_wtag), .rdata(tag_q1)
    );
    way_ram #(.T(line_t)) u_data0 (
        .clk(clk), .addr(ram_index), .we(data_we0), .wdata(ram_wline), .rdata(line_q0)
    );
    way_ram #(.T(line_t)) u_data1 (
        .clk(clk), .addr(ram_index), .we(data_we1), .wdata(ram_wline), .rdata(line_q1)
    );

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// File: verif/dcache_tb.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_tb;

    import dcache_pkg::*;

    logic                  clk;
    logic                  resetn;
    logic                  valid;
    logic                  op;
    tag_t                  tag;
    index_t                index;
    offset_t               offset;
    logic [3:0]            wstrb;
    logic [31:0]           wdata;
    logic                  addr_ok;
    logic                  data_ok;
    logic [31:0]           rdata;
    logic                  rd_req;
    logic [`DC_ADDR_W-1:0] rd_addr;
    logic                  rd_rdy;
    logic                  ret_valid;
    logic                  ret_last;
    logic [31:0]           ret_data;
    logic                  wr_req;
    logic [`DC_ADDR_W-1:0] wr_addr;
    line_t                 wr_data;
    logic                  wr_rdy;

    // 1 KB backing store, address bits above 9 wrap around
    logic [31:0] mem_words  [256];
    logic [31:0] gold_words [256];
    logic [31:0] rng_state;

    // most recent accepted request, the one a refill serves
    int          last_idx;

    // request table, one entry per pipe request
    string       tbl_name   [$];
    logic        tbl_op     [$];
    logic [31:0] tbl_addr   [$];
    logic [3:0]  tbl_strb   [$];
    logic [31:0] tbl_data   [$];
    logic        tbl_chk    [$];
    logic [31:0] tbl_exp    [$];
    int          acc_cycle  [$];
    int          done_cycle [$];
    int          order      [$];

    tb_clock u_clock (.clk(clk));

    dcache u_dcache (.*);

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] waddr);
        return {waddr ^ 8'ha5, waddr + 8'h3c, waddr, ~waddr};
    endfunction

    function automatic logic [31:0] merge_word(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  strb);
        logic [31:0] res;
        for (int b = 0; b < 4; b++) begin
            res[8*b +: 8] = strb[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return res;
    endfunction

    function automatic void add_entry(input string name, input logic is_wr,
                                      input logic [31:0] addr, input logic [3:0] strb,
                                      input logic [31:0] data, input logic chk);
        tbl_name.push_back(name);
        tbl_op.push_back(is_wr);
        tbl_addr.push_back(addr);
        tbl_strb.push_back(strb);
        tbl_data.push_back(data);
        tbl_chk.push_back(chk);
        tbl_exp.push_back(32'h0);
        acc_cycle.push_back(0);
        done_cycle.push_back(0);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("Error: %s expected %08h actual %08h", name, exp_v, act_v);
        $display("*** TEST FAILED ***");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "check failed");
    endtask

    // read channel, random stall on rd_rdy, words in order with random gaps
    initial begin : read_channel
        logic [5:0] line_sel;
        int         gap;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = 32'h0;
        forever begin
            @(negedge clk);
            if (rd_req === 1'b1) begin
                assert (rd_addr == {tbl_addr[last_idx][31:4], 4'h0})
                    else report_mismatch({tbl_name[last_idx], " rd_addr"},
                                         {tbl_addr[last_idx][31:4], 4'h0}, rd_addr);
                repeat (next_random() % 4) @(negedge clk);
                rd_rdy   = 1'b1;
                line_sel = rd_addr[9:4];
                @(negedge clk);
                rd_rdy = 1'b0;
                for (int w = 0; w < `DC_WORDS; w++) begin
                    gap       = next_random() % 2;
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                    repeat (gap) @(negedge clk);
                    ret_valid = 1'b1;
                    ret_last  = (w == `DC_WORDS - 1);
                    ret_data  = mem_words[{line_sel, w[1:0]}];
                    @(negedge clk);
                end
                ret_valid = 1'b0;
                ret_last  = 1'b0;
            end
        end
    end

    // write channel, line lands in the store when wr_rdy goes high
    initial begin : write_channel
        wr_rdy = 1'b0;
        forever begin
            @(negedge clk);
            if (wr_req === 1'b1) begin
                // only lines in the low 1 KB are ever stored to
                assert (wr_addr[31:10] == '0 && wr_addr[3:0] == 4'h0)
                    else report_failure("write-back address is not a stored line");
                repeat (next_random() % 4) @(negedge clk);
                wr_rdy = 1'b1;
                for (int w = 0; w < `DC_WORDS; w++) begin
                    mem_words[{wr_addr[9:4], w[1:0]}] = wr_data[w*32 +: 32];
                end
                @(negedge clk);
                wr_rdy = 1'b0;
            end
        end
    end

    initial begin : run
        int          next_idx;
        int          cycle;
        int          stall_cnt;
        int          busy_cnt;
        int          k;
        int          b2b;
        logic        taking;
        logic [7:0]  widx;
        logic [31:0] r;
        rng_state = 32'hc802_3720;
        last_idx  = 0;
        resetn    = 1'b0;
        valid     = 1'b0;
        op        = 1'b0;
        tag       = '0;
        index     = '0;
        offset    = '0;
        wstrb     = 4'h0;
        wdata     = 32'h0;
        for (int w = 0; w < 256; w++) begin
            mem_words[w[7:0]]  = fill_word(w[7:0]);
            gold_words[w[7:0]] = fill_word(w[7:0]);
        end

        // addr is {tag, index, offset}
        add_entry("rd_miss", 1'b0, 32'h014, 4'h0, 32'h0, 1'b1);
        add_entry("rd_hit", 1'b0, 32'h014, 4'h0, 32'h0, 1'b1);
        add_entry("wr_hit_part", 1'b1, 32'h018, 4'b0101, 32'hdead_beef, 1'b1);
        add_entry("rd_after_wr", 1'b0, 32'h018, 4'h0, 32'h0, 1'b1);
        add_entry("wr_miss", 1'b1, 32'h128, 4'b1100, 32'h1234_5678, 1'b1);
        add_entry("rd_wr_miss", 1'b0, 32'h128, 4'h0, 32'h0, 1'b1);
        add_entry("rd_line_w0", 1'b0, 32'h120, 4'h0, 32'h0, 1'b1);
        add_entry("rd_line_w3", 1'b0, 32'h12c, 4'h0, 32'h0, 1'b1);
        // four tags on set 5, both dirty lines get evicted
        add_entry("wr_tag0_s5", 1'b1, 32'h050, 4'hf, 32'hcafe_0001, 1'b1);
        add_entry("wr_tag1_s5", 1'b1, 32'h154, 4'h3, 32'hcafe_0002, 1'b1);
        add_entry("rd_tag2_s5", 1'b0, 32'h250, 4'h0, 32'h0, 1'b1);
        add_entry("rd_tag3_s5", 1'b0, 32'h350, 4'h0, 32'h0, 1'b1);
        add_entry("rd_tag0_s5", 1'b0, 32'h050, 4'h0, 32'h0, 1'b1);
        add_entry("rd_tag1_s5", 1'b0, 32'h154, 4'h0, 32'h0, 1'b1);
        b2b = tbl_name.size();
        add_entry("b2b_a", 1'b0, 32'h010, 4'h0, 32'h0, 1'b1);
        add_entry("b2b_b", 1'b0, 32'h01c, 4'h0, 32'h0, 1'b1);
        add_entry("b2b_c", 1'b0, 32'h124, 4'h0, 32'h0, 1'b1);
        for (int n = 0; n < 40; n++) begin
            r = next_random();
            add_entry($sformatf("random_%0d", n), r[16],
                      {22'd0, r[9:8], 2'b00, r[5:4], r[3:2], 2'b00},
                      r[23:20] | 4'b0001, next_random(), 1'b1);
        end
        // tags 0x40 and 0x41 are never cached before, so both ways of each set go
        for (int s = 0; s < `DC_SETS; s++) begin
            add_entry($sformatf("flush_a_%0d", s), 1'b0, {24'h40, s[3:0], 4'h0},
                      4'h0, 32'h0, 1'b0);
            add_entry($sformatf("flush_b_%0d", s), 1'b0, {24'h41, s[3:0], 4'h0},
                      4'h0, 32'h0, 1'b0);
        end

        repeat (2) @(negedge clk);
        resetn = 1'b1;
        assert (addr_ok && !data_ok && !rd_req && !wr_req)
            else report_failure("pipe and memory outputs not idle after reset");

        next_idx  = 0;
        cycle     = 0;
        stall_cnt = 0;
        busy_cnt  = 0;
        while (next_idx < tbl_name.size() || order.size() > 0) begin
            taking = 1'b0;
            if (next_idx < tbl_name.size()) begin
                valid  = 1'b1;
                op     = tbl_op[next_idx];
                tag    = tbl_addr[next_idx][31:8];
                index  = tbl_addr[next_idx][7:4];
                offset = tbl_addr[next_idx][3:0];
                wstrb  = tbl_strb[next_idx];
                wdata  = tbl_data[next_idx];
                // addr_ok only changes on the rising edge
                taking = addr_ok;
            end else begin
                valid = 1'b0;
            end
            if (taking) begin
                widx = tbl_addr[next_idx][9:2];
                if (tbl_op[next_idx] == 1'b0) begin
                    tbl_exp[next_idx] = gold_words[widx];
                end else begin
                    gold_words[widx] = merge_word(gold_words[widx], tbl_data[next_idx],
                                                  tbl_strb[next_idx]);
                end
                acc_cycle[next_idx] = cycle;
                last_idx = next_idx;
                order.push_back(next_idx);
            end
            @(negedge clk);
            cycle++;
            if (taking) begin
                next_idx++;
                stall_cnt = 0;
            end else if (valid) begin
                stall_cnt++;
                assert (stall_cnt < 100)
                    else report_failure($sformatf("%s not accepted within 100 cycles",
                                                  tbl_name[next_idx]));
            end
            if (data_ok) begin
                assert (order.size() > 0)
                    else report_failure("data_ok pulsed with no request outstanding");
                k = order.pop_front();
                done_cycle[k] = cycle;
                busy_cnt = 0;
                // stores are held, so they answer one cycle after acceptance
                assert (tbl_op[k] == 1'b0 || cycle == acc_cycle[k] + 1)
                    else report_failure($sformatf("%s store not answered in the next cycle",
                                                  tbl_name[k]));
                if (tbl_op[k] == 1'b0 && tbl_chk[k]) begin
                    assert (rdata == tbl_exp[k])
                        else report_mismatch(tbl_name[k], tbl_exp[k], rdata);
                end
            end else if (order.size() > 0) begin
                busy_cnt++;
                assert (busy_cnt < 100)
                    else report_failure($sformatf("no data_ok for %s within 100 cycles",
                                                  tbl_name[order[0]]));
            end
        end
        valid = 1'b0;

        // second read goes in while the first one is in lookup
        assert (acc_cycle[b2b + 1] == acc_cycle[b2b] + 1)
            else report_failure("second read not accepted during the first read hit");
        assert (done_cycle[b2b] == acc_cycle[b2b] + 1
                && done_cycle[b2b + 1] == acc_cycle[b2b + 1] + 1)
            else report_failure("read hits did not answer one cycle after acceptance");

        for (int w = 0; w < 256; w++) begin
            assert (mem_words[w[7:0]] == gold_words[w[7:0]])
                else report_mismatch($sformatf("mem_image word %0d", w),
                                     gold_words[w[7:0]], mem_words[w[7:0]]);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: compile.f
+incdir+source
source/dcache_pkg.sv
source/way_ram.sv
source/way_meta.sv
source/refill_buffer.sv
source/dcache_ctrl.sv
source/dcache.sv
verif/tb_clock.sv
verif/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard source/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(BUILD_DIR)
